// ==== logic/rvAluPkg.sv ====
`default_nettype none

package rvAluPkg;

    // Widths fixed by the RV32I encoding
    typedef logic [31:0] dataWord;      // Operand, immediate, pc, result
    typedef logic [31:0] instrWord;     // Raw instruction
    typedef logic [6:0]  opcodeField;   // instr[6:0]
    typedef logic [2:0]  aluOpClass;    // Instruction class for aluDecode
    typedef logic [3:0]  aluCtrl;       // Operation select for aluExecute

    // Supported major opcodes
    localparam opcodeField OpRType  = 7'b0110011;   // add, sub, sll ...
    localparam opcodeField OpIType  = 7'b0010011;   // addi, slli ...
    localparam opcodeField OpBranch = 7'b1100011;   // beq .. bgeu
    localparam opcodeField OpJalr   = 7'b1100111;   // jalr

    // Class codes handed from mainDecode to aluDecode
    localparam aluOpClass AluOpR      = 3'b000;
    localparam aluOpClass AluOpI      = 3'b001;
    localparam aluOpClass AluOpBranch = 3'b100;
    localparam aluOpClass AluOpJalr   = 3'b101;

    // Arithmetic and logic codes, shared by R and I type
    localparam aluCtrl CtrlAdd  = 4'd0;
    localparam aluCtrl CtrlSub  = 4'd1;
    localparam aluCtrl CtrlAnd  = 4'd2;
    localparam aluCtrl CtrlOr   = 4'd3;
    localparam aluCtrl CtrlXor  = 4'd4;
    localparam aluCtrl CtrlSll  = 4'd5;
    localparam aluCtrl CtrlSrl  = 4'd6;
    localparam aluCtrl CtrlSra  = 4'd7;
    localparam aluCtrl CtrlSlt  = 4'd8;
    localparam aluCtrl CtrlSltu = 4'd9;

    // Branch compare codes
    localparam aluCtrl CtrlBeq  = 4'd10;
    localparam aluCtrl CtrlBne  = 4'd11;
    localparam aluCtrl CtrlBlt  = 4'd12;
    localparam aluCtrl CtrlBge  = 4'd13;
    localparam aluCtrl CtrlBltu = 4'd14;
    localparam aluCtrl CtrlBgeu = 4'd15;

endpackage

`default_nettype wire

// ==== logic/mainDecode.sv ====
`timescale 1ns/100ps
`default_nettype none

module mainDecode (
    input  wire                        clk,
    input  wire                        reset,        // Sync, active high
    input  wire                        instrValid,
    output logic                       instrReady,
    input  wire rvAluPkg::instrWord    instr,
    input  wire rvAluPkg::dataWord     rs1Value,
    input  wire rvAluPkg::dataWord     rs2Value,
    input  wire rvAluPkg::dataWord     pc,
    output logic                       decValid,
    input  wire                        decReady,     // From resultStage
    output rvAluPkg::aluOpClass        aluOp,
    output logic [2:0]                 funct3,       // instr[14:12]
    output logic                       funct7b5,     // instr[30]
    output rvAluPkg::dataWord          srcA,
    output rvAluPkg::dataWord          srcB,
    output rvAluPkg::dataWord          pcD,
    output rvAluPkg::dataWord          immD,
    output logic                       illegalD
);

    rvAluPkg::opcodeField opcode;
    rvAluPkg::dataWord    iImm;           // Sign-extended I immediate
    rvAluPkg::dataWord    bImm;           // Sign-extended B immediate
    rvAluPkg::dataWord    immNext;
    rvAluPkg::aluOpClass  aluOpNext;
    logic                 useRs2;         // R type and branches read rs2
    logic                 illegalNext;
    logic                 load;

    assign opcode = instr[6:0];
    assign iImm   = {{20{instr[31]}}, instr[31:20]};
    assign bImm   = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    // Opcode decode
    always_comb begin
        aluOpNext   = rvAluPkg::AluOpR;
        immNext     = iImm;
        useRs2      = 1'b0;
        illegalNext = 1'b0;
        case (opcode)
            rvAluPkg::OpRType: begin
                aluOpNext = rvAluPkg::AluOpR;
                useRs2    = 1'b1;                    // Register-register
            end
            rvAluPkg::OpIType: begin
                aluOpNext = rvAluPkg::AluOpI;        // Shamt sits in imm[4:0]
            end
            rvAluPkg::OpBranch: begin
                aluOpNext = rvAluPkg::AluOpBranch;
                immNext   = bImm;                    // Branch offset
                useRs2    = 1'b1;                    // Compare rs1 with rs2
            end
            rvAluPkg::OpJalr: begin
                aluOpNext = rvAluPkg::AluOpJalr;
            end
            default: begin
                illegalNext = 1'b1;                  // Anything else unsupported
            end
        endcase
    end

    // Stage accepts when empty or draining downstream
    assign instrReady = ~decValid | decReady;
    assign load       = instrValid & instrReady;

    always_ff @(posedge clk) begin
        if (reset) begin
            decValid <= 1'b0;
        end else if (instrReady) begin
            decValid <= instrValid;                  // Bubble if no input
        end
    end

    // Decoded payload captured on each transfer
    always_ff @(posedge clk) begin
        if (load) begin
            aluOp    <= aluOpNext;
            funct3   <= instr[14:12];
            funct7b5 <= instr[30];
            srcA     <= rs1Value;
            srcB     <= useRs2 ? rs2Value : immNext;
            pcD      <= pc;
            immD     <= immNext;
            illegalD <= illegalNext;
        end
    end

endmodule

`default_nettype wire

// ==== logic/aluDecode.sv ====
`timescale 1ns/100ps
`default_nettype none

module aluDecode (
    input  wire rvAluPkg::aluOpClass aluOp,     // Class from mainDecode
    input  wire [2:0]                funct3,    // instr[14:12]
    input  wire                      funct7b5,  // instr[30]
    output rvAluPkg::aluCtrl         ctrl
);

    always_comb begin
        case (aluOp)
            // Register-register, funct3 and bit 30 together
            rvAluPkg::AluOpR: begin
                case ({funct3, funct7b5})
                    4'b0000: ctrl = rvAluPkg::CtrlAdd;
                    4'b0001: ctrl = rvAluPkg::CtrlSub;
                    4'b0010: ctrl = rvAluPkg::CtrlSll;
                    4'b0100: ctrl = rvAluPkg::CtrlSlt;
                    4'b0110: ctrl = rvAluPkg::CtrlSltu;
                    4'b1000: ctrl = rvAluPkg::CtrlXor;
                    4'b1010: ctrl = rvAluPkg::CtrlSrl;
                    4'b1011: ctrl = rvAluPkg::CtrlSra;
                    4'b1100: ctrl = rvAluPkg::CtrlOr;
                    4'b1110: ctrl = rvAluPkg::CtrlAnd;
                    default: ctrl = rvAluPkg::CtrlAdd;   // Unknown funct7 combo
                endcase
            end

            // Immediate forms, bit 30 is part of the immediate
            rvAluPkg::AluOpI: begin
                case (funct3)
                    3'b000:  ctrl = rvAluPkg::CtrlAdd;   // addi, no subi
                    3'b001:  ctrl = rvAluPkg::CtrlSll;
                    3'b010:  ctrl = rvAluPkg::CtrlSlt;
                    3'b011:  ctrl = rvAluPkg::CtrlSltu;
                    3'b100:  ctrl = rvAluPkg::CtrlXor;
                    3'b101: begin
                        // Right shift only place bit 30 matters here
                        ctrl = funct7b5 ? rvAluPkg::CtrlSra : rvAluPkg::CtrlSrl;
                    end
                    3'b110:  ctrl = rvAluPkg::CtrlOr;
                    default: ctrl = rvAluPkg::CtrlAnd;   // 3'b111
                endcase
            end

            // Conditional branches
            rvAluPkg::AluOpBranch: begin
                case (funct3)
                    3'b000:  ctrl = rvAluPkg::CtrlBeq;
                    3'b001:  ctrl = rvAluPkg::CtrlBne;
                    3'b100:  ctrl = rvAluPkg::CtrlBlt;
                    3'b101:  ctrl = rvAluPkg::CtrlBge;
                    3'b110:  ctrl = rvAluPkg::CtrlBltu;
                    3'b111:  ctrl = rvAluPkg::CtrlBgeu;
                    default: ctrl = rvAluPkg::CtrlAdd;   // Reserved funct3
                endcase
            end

            // jalr target is rs1 + imm
            rvAluPkg::AluOpJalr: ctrl = rvAluPkg::CtrlAdd;

            default: ctrl = rvAluPkg::CtrlAdd;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/aluExecute.sv ====
`timescale 1ns/100ps
`default_nettype none

module aluExecute (
    input  wire rvAluPkg::aluCtrl    ctrl,
    input  wire rvAluPkg::aluOpClass aluOp,
    input  wire rvAluPkg::dataWord   srcA,      // rs1
    input  wire rvAluPkg::dataWord   srcB,      // rs2 or immediate
    input  wire rvAluPkg::dataWord   pcD,
    input  wire rvAluPkg::dataWord   immD,
    input  wire                      illegalD,
    output rvAluPkg::dataWord        exResult,
    output logic                     exTaken
);

    rvAluPkg::dataWord aluValue;
    logic [4:0]        shamt;
    logic              isEqual;
    logic              lessSigned;
    logic              lessUnsigned;
    logic              cmpTrue;            // Branch condition met

    assign shamt        = srcB[4:0];       // Low 5 bits only
    assign isEqual      = (srcA == srcB);
    assign lessSigned   = ($signed(srcA) < $signed(srcB));
    assign lessUnsigned = (srcA < srcB);

    // Arithmetic, logic, shift and set-less-than
    always_comb begin
        case (ctrl)
            rvAluPkg::CtrlAdd:  aluValue = srcA + srcB;
            rvAluPkg::CtrlSub:  aluValue = srcA - srcB;
            rvAluPkg::CtrlAnd:  aluValue = srcA & srcB;
            rvAluPkg::CtrlOr:   aluValue = srcA | srcB;
            rvAluPkg::CtrlXor:  aluValue = srcA ^ srcB;
            rvAluPkg::CtrlSll:  aluValue = srcA << shamt;
            rvAluPkg::CtrlSrl:  aluValue = srcA >> shamt;
            rvAluPkg::CtrlSra:  aluValue = $signed(srcA) >>> shamt;   // Sign fill
            rvAluPkg::CtrlSlt:  aluValue = {31'd0, lessSigned};
            rvAluPkg::CtrlSltu: aluValue = {31'd0, lessUnsigned};
            default:            aluValue = '0;                        // Branch codes
        endcase
    end

    // Branch comparator
    always_comb begin
        case (ctrl)
            rvAluPkg::CtrlBeq:  cmpTrue = isEqual;
            rvAluPkg::CtrlBne:  cmpTrue = ~isEqual;
            rvAluPkg::CtrlBlt:  cmpTrue = lessSigned;
            rvAluPkg::CtrlBge:  cmpTrue = ~lessSigned;
            rvAluPkg::CtrlBltu: cmpTrue = lessUnsigned;
            rvAluPkg::CtrlBgeu: cmpTrue = ~lessUnsigned;
            default:            cmpTrue = 1'b0;
        endcase
    end

    // Final value per class
    always_comb begin
        exResult = aluValue;
        exTaken  = 1'b0;
        if (illegalD) begin
            exResult = '0;                                   // Flagged, no value
            exTaken  = 1'b0;
        end else if (aluOp == rvAluPkg::AluOpBranch) begin
            exResult = pcD + immD;                           // Branch target
            exTaken  = cmpTrue;
        end else if (aluOp == rvAluPkg::AluOpJalr) begin
            exResult = {aluValue[31:1], 1'b0};               // rs1 + imm, LSB cleared
            exTaken  = 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== logic/resultStage.sv ====
`timescale 1ns/100ps
`default_nettype none

module resultStage (
    input  wire                    clk,
    input  wire                    reset,          // Sync, active high
    input  wire                    decValid,
    output logic                   decReady,
    input  wire rvAluPkg::dataWord exResult,
    input  wire                    exTaken,
    input  wire                    illegalD,
    output logic                   resultValid,
    input  wire                    resultReady,
    output rvAluPkg::dataWord      result,
    output logic                   branchTaken,
    output logic                   illegal
);

    logic load;

    // Free slot when empty or being drained this cycle
    assign decReady = ~resultValid | resultReady;
    assign load     = decValid & decReady;

    always_ff @(posedge clk) begin
        if (reset) begin
            resultValid <= 1'b0;
        end else if (decReady) begin
            resultValid <= decValid;               // Empties if nothing arrives
        end
    end

    // Held stable under back-pressure
    always_ff @(posedge clk) begin
        if (load) begin
            result      <= exResult;
            branchTaken <= exTaken;
            illegal     <= illegalD;
        end
    end

endmodule

`default_nettype wire

// ==== logic/aluCore.sv ====
`timescale 1ns/100ps
`default_nettype none

module aluCore (
    input  wire                     clk,
    input  wire                     reset,         // Sync, active high
    input  wire                     instrValid,
    output logic                    instrReady,
    input  wire rvAluPkg::instrWord instr,
    input  wire rvAluPkg::dataWord  rs1Value,
    input  wire rvAluPkg::dataWord  rs2Value,
    input  wire rvAluPkg::dataWord  pc,
    output logic                    resultValid,
    input  wire                     resultReady,
    output rvAluPkg::dataWord       result,
    output logic                    branchTaken,
    output logic                    illegal
);

    // Decode stage to execute
    logic                decValid;
    logic                decReady;
    rvAluPkg::aluOpClass aluOp;
    logic [2:0]          funct3;
    logic                funct7b5;
    rvAluPkg::dataWord   srcA;
    rvAluPkg::dataWord   srcB;
    rvAluPkg::dataWord   pcD;
    rvAluPkg::dataWord   immD;
    logic                illegalD;

    // Execute to result stage
    rvAluPkg::aluCtrl    ctrl;
    rvAluPkg::dataWord   exResult;
    logic                exTaken;

    mainDecode uDecode (
        .clk(clk), .reset(reset),
        .instrValid(instrValid), .instrReady(instrReady),
        .instr(instr), .rs1Value(rs1Value), .rs2Value(rs2Value), .pc(pc),
        .decValid(decValid), .decReady(decReady),
        .aluOp(aluOp), .funct3(funct3), .funct7b5(funct7b5),
        .srcA(srcA), .srcB(srcB), .pcD(pcD), .immD(immD), .illegalD(illegalD)
    );

    aluDecode uAluDecode (
        .aluOp(aluOp), .funct3(funct3), .funct7b5(funct7b5), .ctrl(ctrl)
    );

    aluExecute uExecute (
        .ctrl(ctrl), .aluOp(aluOp), .srcA(srcA), .srcB(srcB),
        .pcD(pcD), .immD(immD), .illegalD(illegalD),
        .exResult(exResult), .exTaken(exTaken)
    );

    resultStage uResult (
        .clk(clk), .reset(reset),
        .decValid(decValid), .decReady(decReady),
        .exResult(exResult), .exTaken(exTaken), .illegalD(illegalD),
        .resultValid(resultValid), .resultReady(resultReady),
        .result(result), .branchTaken(branchTaken), .illegal(illegal)
    );

endmodule

`default_nettype wire

// ==== verification/aluCore_props.sv ====
`timescale 1ns/100ps
`default_nettype none

module aluCoreProps (
    input wire                    clk,
    input wire                    reset,
    input wire                    instrValid,
    input wire                    instrReady,
    input wire                    resultValid,
    input wire                    resultReady,
    input wire rvAluPkg::dataWord result,
    input wire                    branchTaken,
    input wire                    illegal
);

    logic [2:0] pendingCount;                        // Accepted but not delivered

    always_ff @(posedge clk) begin
        if (reset) begin
            pendingCount <= '0;
        end else begin
            pendingCount <= pendingCount + {2'b0, instrValid & instrReady}
                                         - {2'b0, resultValid & resultReady};
        end
    end

    resultHeld: assert property (@(posedge clk) disable iff (reset)
        (resultValid && !resultReady) |=>
            (resultValid && $stable(result) && $stable(branchTaken) && $stable(illegal)))
        else $error("Output changed while the sink was stalling");

    resultLowAfterReset: assert property (@(posedge clk) reset |=> !resultValid)
        else $error("resultValid high right after reset");

    readyHighAfterReset: assert property (@(posedge clk) reset |=> instrReady)
        else $error("instrReady low right after reset");

    noResultWithoutInput: assert property (@(posedge clk) disable iff (reset)
        resultValid |-> (pendingCount != 3'd0))
        else $error("Result presented with no instruction accepted");

endmodule

bind aluCore aluCoreProps uProps (
    .clk(clk), .reset(reset),
    .instrValid(instrValid), .instrReady(instrReady),
    .resultValid(resultValid), .resultReady(resultReady),
    .result(result), .branchTaken(branchTaken), .illegal(illegal)
);

`default_nettype wire

// ==== verification/aluCoreTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module aluCoreTb;

    localparam int NumInstr = 400;                  // Instructions per run

    logic               clk = 1'b0;
    logic               reset;
    logic               instrValid;
    logic               instrReady;
    rvAluPkg::instrWord instr;
    rvAluPkg::dataWord  rs1Value;
    rvAluPkg::dataWord  rs2Value;
    rvAluPkg::dataWord  pc;
    logic               resultValid;
    logic               resultReady;
    rvAluPkg::dataWord  result;
    logic               branchTaken;
    logic               illegal;

    logic [31:0] lfsrState = 32'd69324;             // Seed
    logic [33:0] expQueue[$];                       // {result, taken, illegal}
    int          sent = 0;
    int          received = 0;
    int          mismatchCount = 0;
    int          otherErrors = 0;

    aluCore uut (
        .clk(clk), .reset(reset),
        .instrValid(instrValid), .instrReady(instrReady),
        .instr(instr), .rs1Value(rs1Value), .rs2Value(rs2Value), .pc(pc),
        .resultValid(resultValid), .resultReady(resultReady),
        .result(result), .branchTaken(branchTaken), .illegal(illegal)
    );

    always #20 clk = ~clk;                          // 40 ns period

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic randomBits(input int n, output logic [31:0] v);
        v = '0;
        repeat (n) begin
            lfsrState = lfsrNext(lfsrState);
            v = {v[30:0], lfsrState[0]};            // One step per bit
        end
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        mismatchCount++;
        $display("Mismatch %s: got %h expected %h", name, got, exp);
    endtask

    // Expected outputs straight from the RV32I rules
    function automatic logic [33:0] modelResult(input rvAluPkg::instrWord ins,
                                                input rvAluPkg::dataWord a,
                                                input rvAluPkg::dataWord b,
                                                input rvAluPkg::dataWord p);
        rvAluPkg::dataWord iImm;
        rvAluPkg::dataWord bImm;
        rvAluPkg::dataWord opB;
        rvAluPkg::dataWord res;
        logic              taken;
        logic [4:0]        sh;
        iImm  = {{20{ins[31]}}, ins[31:20]};
        bImm  = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        res   = '0;
        taken = 1'b0;
        case (ins[6:0])
            rvAluPkg::OpRType, rvAluPkg::OpIType: begin
                opB = (ins[6:0] == rvAluPkg::OpRType) ? b : iImm;
                sh  = opB[4:0];
                case (ins[14:12])
                    3'b000: res = (ins[6:0] == rvAluPkg::OpRType && ins[30]) ? a - opB : a + opB;
                    3'b001: res = a << sh;
                    3'b010: res = ($signed(a) < $signed(opB)) ? 32'd1 : 32'd0;
                    3'b011: res = (a < opB) ? 32'd1 : 32'd0;
                    3'b100: res = a ^ opB;
                    3'b101: begin
                        if (ins[30]) res = $signed(a) >>> sh;   // Arithmetic
                        else res = a >> sh;
                    end
                    3'b110: res = a | opB;
                    default: res = a & opB;
                endcase
            end
            rvAluPkg::OpBranch: begin
                res = p + bImm;                               // Target
                case (ins[14:12])
                    3'b000:  taken = (a == b);
                    3'b001:  taken = (a != b);
                    3'b100:  taken = ($signed(a) < $signed(b));
                    3'b101:  taken = ($signed(a) >= $signed(b));
                    3'b110:  taken = (a < b);
                    3'b111:  taken = (a >= b);
                    default: taken = 1'b0;
                endcase
            end
            rvAluPkg::OpJalr: begin
                res   = (a + iImm) & ~32'd1;
                taken = 1'b1;
            end
            default: return {32'd0, 1'b0, 1'b1};              // Unsupported opcode
        endcase
        return {res, taken, 1'b0};
    endfunction

    // Random legal encoding per class, plus operands and pc
    task automatic makeInstr(output rvAluPkg::instrWord ins, output rvAluPkg::dataWord a,
                             output rvAluPkg::dataWord b, output rvAluPkg::dataWord p);
        logic [31:0]          r;
        logic [2:0]           kind;
        logic [2:0]           f3;
        logic                 alt;
        logic [11:0]          imm;
        logic [4:0]           rs1f;
        logic [4:0]           rs2f;
        logic [4:0]           rd;
        rvAluPkg::opcodeField op;
        randomBits(3, r);
        kind = r[2:0];
        randomBits(15, r);
        rs1f = r[4:0];
        rs2f = r[9:5];
        rd   = r[14:10];
        randomBits(3, r);
        f3 = r[2:0];
        randomBits(1, r);
        alt = r[0];
        randomBits(12, r);
        imm = r[11:0];
        if (kind <= 3'd1) begin
            if (f3 != 3'b000 && f3 != 3'b101) alt = 1'b0;     // Bit 30 only on sub, sra
            ins = {1'b0, alt, 5'b0, rs2f, rs1f, f3, rd, rvAluPkg::OpRType};
        end else if (kind <= 3'd3) begin
            if (f3 == 3'b001) imm[11:5] = 7'b0;               // slli
            else if (f3 == 3'b101) imm[11:5] = {1'b0, alt, 5'b0};
            ins = {imm, rs1f, f3, rd, rvAluPkg::OpIType};
        end else if (kind <= 3'd5) begin
            if (f3[2:1] == 2'b01) f3[2] = 1'b1;               // Skip reserved funct3
            ins = {imm[11], imm[9:4], rs2f, rs1f, f3, imm[3:0], imm[10], rvAluPkg::OpBranch};
        end else if (kind == 3'd6) begin
            ins = {imm, rs1f, 3'b000, rd, rvAluPkg::OpJalr};
        end else begin
            randomBits(7, r);
            op = r[6:0];
            if (op == rvAluPkg::OpRType || op == rvAluPkg::OpIType ||
                op == rvAluPkg::OpBranch || op == rvAluPkg::OpJalr) begin
                op = op ^ 7'b1000000;                         // Lands on an unused opcode
            end
            randomBits(25, r);
            ins = {r[24:0], op};
        end
        randomBits(32, a);
        randomBits(2, r);
        case (r[1:0])
            2'd0:    b = a;                                   // Equal
            2'd1:    randomBits(32, b);
            2'd2:    b = a ^ 32'h8000_0000;                   // Signed and unsigned disagree
            default: begin
                randomBits(3, r);
                b = a - 32'd4 + {29'd0, r[2:0]};              // Near neighbour
            end
        endcase
        randomBits(32, p);
        p[1:0] = 2'b00;
    endtask

    // Input side monitor
    always @(posedge clk) begin
        if (!reset && instrValid && instrReady) begin
            expQueue.push_back(modelResult(instr, rs1Value, rs2Value, pc));
        end
    end

    // Output side scoreboard
    always @(posedge clk) begin
        logic [33:0] head;
        if (!reset && resultValid && resultReady) begin
            received++;
            if (expQueue.size() == 0) begin
                otherErrors++;
                $display("Result delivered with no instruction pending");
            end else begin
                head = expQueue.pop_front();
                assert (result === head[33:2])
                    else reportMismatch("result", result, head[33:2]);
                assert (branchTaken === head[1])
                    else reportMismatch("branchTaken", {31'd0, branchTaken}, {31'd0, head[1]});
                assert (illegal === head[0])
                    else reportMismatch("illegal", {31'd0, illegal}, {31'd0, head[0]});
            end
        end
    end

    // Input stalls only with both stages full and output blocked
    always @(negedge clk) begin
        logic readyExp;
        if (!reset) begin
            readyExp = (expQueue.size() < 2) || resultReady;
            assert (instrReady === readyExp)
                else reportMismatch("instrReady", {31'd0, instrReady}, {31'd0, readyExp});
        end
    end

    initial begin
        rvAluPkg::instrWord nextInstr;
        rvAluPkg::dataWord  nextA;
        rvAluPkg::dataWord  nextB;
        rvAluPkg::dataWord  nextPc;
        logic [31:0]        r;
        reset       = 1'b1;
        instrValid  = 1'b0;
        instr       = '0;
        rs1Value    = '0;
        rs2Value    = '0;
        pc          = '0;
        resultReady = 1'b0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        assert (resultValid === 1'b0)
            else reportMismatch("resultValid", {31'd0, resultValid}, 32'h0);
        assert (instrReady === 1'b1)
            else reportMismatch("instrReady", {31'd0, instrReady}, 32'h1);
        while (sent < NumInstr) begin
            @(posedge clk);
            if (instrValid && instrReady) sent++;              // Accepted at this edge
            if (!instrValid || instrReady) begin
                randomBits(2, r);
                if (sent >= NumInstr || r[1:0] == 2'd0) begin
                    instrValid <= 1'b0;                         // Gap
                end else begin
                    makeInstr(nextInstr, nextA, nextB, nextPc);
                    instr      <= nextInstr;
                    rs1Value   <= nextA;
                    rs2Value   <= nextB;
                    pc         <= nextPc;
                    instrValid <= 1'b1;
                end
            end
            randomBits(2, r);
            resultReady <= (r[1:0] != 2'd0);                    // Low one cycle in four
        end
        @(posedge clk);
        resultReady <= 1'b1;                                    // Drain
        wait (received == NumInstr);
        repeat (5) @(posedge clk);                              // Catch strays
        @(negedge clk);
        assert (expQueue.size() == 0) else begin
            otherErrors++;
            $display("Instructions left without a result: %0d", expQueue.size());
        end
        $display("Done: %0d mismatches, %0d other errors, %0d of %0d results",
                 mismatchCount, otherErrors, received, NumInstr);
        if (mismatchCount == 0 && otherErrors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Watchdog, 20 cycles per instruction plus margin
    initial begin
        repeat (NumInstr * 20 + 100) @(posedge clk);
        $display("Timeout: only %0d of %0d results arrived", received, NumInstr);
        $display("Done: %0d mismatches, %0d other errors, %0d of %0d results",
                 mismatchCount, otherErrors, received, NumInstr);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
logic/rvAluPkg.sv
logic/mainDecode.sv
logic/aluDecode.sv
logic/aluExecute.sv
logic/resultStage.sv
logic/aluCore.sv
verification/aluCore_props.sv
verification/aluCoreTb.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
# Build and run the aluCore testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --assert --top-module aluCoreTb -f src.f -o aluCoreSim

./obj_dir/aluCoreSim 2>&1 | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    echo "runSim: failure reported in sim.log"
    exit 1
fi

if ! grep -q "SIMULATION PASSED" sim.log; then
    echo "runSim: no pass line in sim.log"
    exit 1
fi

echo "runSim: ok"
